/* rtl/pr_consts.svh */
/*
	Build-time constants for the register unit
	Included by the package and by every module that sizes buses or registers
*/

`ifndef PR_CONSTS_SVH
`define PR_CONSTS_SVH

`define PR_CPU_NUMBER 1'b0	// Processor number on the system bus, 0 or 1
`define PR_WORD 16	// Data word width
`define PR_NREGS 8	// Register addresses, R0 at address 0

// L bus source codes, pr_ctl to pr_rfile
`define PR_L_ZERO 2'd0	// Bus idle
`define PR_L_REG 2'd1	// Addressed user register
`define PR_L_R0 2'd2	// Whole R0
`define PR_L_BLR 2'd3	// R0 bits 0..7 moved to 8..15

`endif

/* rtl/pr_pkg.sv */
/*
	Types shared by the register unit blocks
	Bit 0 is the MSB as in the CPU docs
*/

`include "pr_consts.svh"

package pr_pkg;

	// CPU flags held in R0 bits 0..8
	typedef struct packed {
		logic z;	// Zero
		logic m;	// Minus
		logic v;	// Overflow
		logic c;	// Carry
		logic l;	// Less
		logic e;	// Equal
		logic g;	// Greater
		logic y;	// Extension Y
		logic x;	// Extension X
	} pr_flags_t;

	// R0 seen as a bus word or split into flags and user bits
	typedef union packed {
		logic [0:`PR_WORD-1] word;	// Raw word, as LPC and bus reads see it
		struct packed {
			pr_flags_t flags;	// Bits 0..8
			logic [0:`PR_WORD-10] user;	// Bits 9..15, user settable
		} fields;
	} pr_r0_u;

	// Register access command from the sequencer
	typedef struct packed {
		logic [2:0] addr;	// 0 is R0, 1..7 user regs
		logic read;
		logic write;
		logic blr;	// Block registers, shows flags on L bits 8..15
	} pr_reg_cmd_t;

	// KI bus source select
	typedef enum logic [1:0] {
		ki_rz = 2'd0,
		ki_state = 2'd1,
		ki_rb = 2'd2,
		ki_zp = 2'd3
	} pr_ki_sel_e;

	// Flag group update strobes
	typedef struct packed {
		logic ust_z;	// Z
		logic ust_mc;	// M and C
		logic ust_v;	// V
		logic ust_leg;	// L, E, G
		logic ust_y;	// Y
		logic ust_x;	// X
	} pr_flag_upd_t;

endpackage

/* rtl/pr_ctl.sv */
/*
	Register unit control decode
	Turns register commands and instruction strobes into write enables and L bus selects
*/

`include "pr_consts.svh"

module pr_ctl import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input pr_reg_cmd_t cmd,	// Address and access type
	input logic strobe,	// Write pulse from the sequencer
	input logic lpc,	// LPC, load whole R0
	input pr_flag_upd_t upd,	// Flag groups to update
	input logic q,	// User mode
	input logic zer_sp,
	input logic clm,	// Master clear
	output logic rf_we,	// Write R1..R7
	output logic [2:0] rf_addr,
	output logic [1:0] l_src,	// L bus source code
	output logic r0_we_full,	// All 16 bits of R0
	output logic r0_we_low,	// R0 bits 8..15 only
	output pr_flag_upd_t r0_flag_we,
	output logic zer	// Clear user bits and Q
);

	logic strobe_q;	// Strobe seen last cycle
	logic stb;	// First cycle of a strobe
	logic addr_r0;	// Command addresses R0
	logic wr;	// Qualified register write

	// Edge detect so a long strobe writes once
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			strobe_q <= 1'b0;
		end else begin
			strobe_q <= strobe;
		end
	end

	assign stb = strobe & ~strobe_q;
	assign addr_r0 = (cmd.addr == 3'd0);
	assign wr = stb & cmd.write;

	// User register file
	assign rf_we = wr & ~addr_r0;
	assign rf_addr = cmd.addr;

	// R0 writes
	// In user mode the sequencer may only touch bits 8..15
	assign r0_we_full = (stb & lpc) | (wr & addr_r0 & ~q);
	assign r0_we_low = wr & addr_r0 & q;

	// Flag groups need the strobe too
	assign r0_flag_we = upd & {$bits(pr_flag_upd_t){stb}};

	assign zer = zer_sp | clm;	// Master clear also drops user state

	// L bus source with blocked registers first
	always_comb begin
		if (cmd.blr) begin
			l_src = `PR_L_BLR;
		end else if (cmd.read) begin
			if (addr_r0) begin
				l_src = `PR_L_R0;
			end else begin
				l_src = `PR_L_REG;
			end
		end else begin
			l_src = `PR_L_ZERO;	// No read, bus stays zero
		end
	end

endmodule

/* rtl/pr_rfile.sv */
/*
	User registers R1..R7 and the L bus read multiplexer
	Writes come from the W bus, reads go out on L together with R0 views
*/

`include "pr_consts.svh"

module pr_rfile import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [0:`PR_WORD-1] w,	// W bus
	input logic rf_we,
	input logic [2:0] rf_addr,	// 1..7 here, 0 never written
	input logic [1:0] l_src,
	input pr_r0_u r0,	// Current status word
	output logic [0:`PR_WORD-1] l	// L bus
);

	localparam int HALF = `PR_WORD / 2;

	logic [0:`PR_WORD-1] regs [1:`PR_NREGS-1];	// R1..R7
	logic [0:`PR_WORD-1] rd_reg;	// Addressed register
	logic [0:`PR_WORD-1] blr_word;	// Flags shifted down a byte

	// Register writes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < `PR_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (rf_we && rf_addr != 3'd0) begin
			regs[rf_addr] <= w;
		end
	end

	// Address 0 has no storage here
	always_comb begin
		if (rf_addr == 3'd0) begin
			rd_reg = '0;
		end else begin
			rd_reg = regs[rf_addr];
		end
	end

	// R0 bits 0..7 land in L bits 8..15
	assign blr_word = {{HALF{1'b0}}, r0.word[0:HALF-1]};

	always_comb begin
		case (l_src)
			`PR_L_REG: l = rd_reg;
			`PR_L_R0: l = r0.word;
			`PR_L_BLR: l = blr_word;
			default: l = '0;
		endcase
	end

endmodule

/* rtl/pr_r0.sv */
/*
	R0 status register, CPU flags in bits 0..8 and user bits in 9..15
	Loads whole or in part from W, updates flags by group from the ALU
*/

`include "pr_consts.svh"

module pr_r0 import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [0:`PR_WORD-1] w,	// W bus
	input logic r0_we_full,	// Load all bits
	input logic r0_we_low,	// Load bits 8..15
	input pr_flag_upd_t r0_flag_we,	// Per group update
	input logic zer,	// Clear user bits
	input logic zs,	// ALU result zero
	input logic s_1,	// Sign before extension
	input logic s0,	// Result sign
	input logic carry,
	input logic aryt,	// Arithmetic compare
	input logic ovf,
	input logic exy,
	input logic exx,
	output pr_r0_u r0
);

	localparam int HALF = `PR_WORD / 2;

	pr_r0_u r0_q;
	logic cmp_g;	// Greater from compare
	logic cmp_l;	// Less from compare

	// Compare rule
	// Arithmetic uses the sign, logical uses the carry
	always_comb begin
		if (aryt) begin
			cmp_g = ~zs & ~s_1;
			cmp_l = s_1;
		end else begin
			cmp_g = carry & ~zs;
			cmp_l = ~carry;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r0_q <= '0;
		end else begin
			if (r0_we_full) begin
				r0_q.word <= w;	// Whole word wins over flags
			end else begin
				if (r0_flag_we.ust_z) begin
					r0_q.fields.flags.z <= zs;
				end
				if (r0_flag_we.ust_mc) begin
					r0_q.fields.flags.m <= s0;
					r0_q.fields.flags.c <= carry;
				end
				if (r0_flag_we.ust_v) begin
					r0_q.fields.flags.v <= ovf;
				end
				if (r0_flag_we.ust_leg) begin
					r0_q.fields.flags.l <= cmp_l;
					r0_q.fields.flags.e <= zs;
					r0_q.fields.flags.g <= cmp_g;
				end
				if (r0_flag_we.ust_y) begin
					r0_q.fields.flags.y <= exy;
				end
				// X sits in bit 8, so a user-mode load owns it
				if (r0_we_low) begin
					r0_q.word[HALF:`PR_WORD-1] <= w[HALF:`PR_WORD-1];
				end else if (r0_flag_we.ust_x) begin
					r0_q.fields.flags.x <= exx;
				end
			end
			if (zer) begin
				r0_q.fields.user <= '0;	// Clear beats any load
			end
		end
	end

	assign r0 = r0_q;

endmodule

/* rtl/pr_sysregs.sv */
/*
	System side registers RB, NB, Q and BS
	Drives the active-low system bus drivers and selects the KI bus source
*/

`include "pr_consts.svh"

module pr_sysregs import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [0:`PR_WORD-1] w,	// W bus
	input logic w_rba,	// RB[10:15]
	input logic w_rbb,	// RB[4:9]
	input logic w_rbc,	// RB[0:3]
	input logic w_bar,	// Load NB, Q, BS
	input logic strobe,
	input logic zer,	// Clears Q
	input logic clm,	// Clears NB and BS
	input logic bar_nb,	// NB onto system bus
	input logic q_nb,	// Q onto system bus
	input logic bp_nb,
	input logic pn_nb,
	input logic rpn,	// Requested processor number
	input pr_ki_sel_e ki_sel,
	input logic [0:`PR_WORD-1] rz,
	input logic [0:`PR_WORD-1] zp,
	input logic [0:9] rs,
	output logic q,	// User mode flag
	output logic [0:3] dnb_n,
	output logic dqb_n,
	output logic dpn_n,
	output logic zgpn,	// Request is for this CPU
	output logic [0:`PR_WORD-1] ki
);

	logic [0:`PR_WORD-1] rb;	// Binary load register
	logic [0:3] nb;	// Block number
	logic bs;

	// RB fields all take the low W bits
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rb <= '0;
		end else if (strobe) begin
			if (w_rba) rb[10:15] <= w[10:15];
			if (w_rbb) rb[4:9] <= w[10:15];
			if (w_rbc) rb[0:3] <= w[12:15];	// Only four bits here
		end
	end

	// NB, BS and Q with clears taking priority
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			nb <= '0;
			bs <= 1'b0;
			q <= 1'b0;
		end else begin
			if (clm) begin
				nb <= '0;
				bs <= 1'b0;
			end else if (strobe && w_bar) begin
				nb <= w[12:15];
				bs <= w[11];
			end
			if (zer) begin
				q <= 1'b0;
			end else if (strobe && w_bar) begin
				q <= w[10];
			end
		end
	end

	assign zgpn = (rpn == `PR_CPU_NUMBER);
	assign dnb_n = bar_nb ? ~nb : 4'hf;	// Released when not enabled
	assign dqb_n = ~(q_nb & q);
	// Low for the other CPU's block or when CPU 1 asserts its number
	assign dpn_n = ~((bp_nb & (bs ^ `PR_CPU_NUMBER)) | (pn_nb & `PR_CPU_NUMBER));

	always_comb begin
		case (ki_sel)
			ki_rz: ki = rz;
			ki_state: ki = {rs, q, bs, nb};	// Processor state word
			ki_rb: ki = rb;
			default: ki = zp;
		endcase
	end

endmodule

/* rtl/pr.sv */
/*
	Register unit top, CPU user registers, R0 and system registers
	Wires the control decode, register file, R0 and system register blocks
*/

`include "pr_consts.svh"

module pr import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [0:`PR_WORD-1] w,	// W bus
	input pr_reg_cmd_t cmd,
	input logic strobe,
	input logic lpc,
	input pr_flag_upd_t upd,
	input logic zs,
	input logic s_1,
	input logic s0,
	input logic carry,
	input logic aryt,
	input logic ovf,
	input logic exy,
	input logic exx,
	input logic w_rba,
	input logic w_rbb,
	input logic w_rbc,
	input logic w_bar,
	input logic clm,
	input logic zer_sp,
	input logic bar_nb,
	input logic q_nb,
	input logic bp_nb,
	input logic pn_nb,
	input logic rpn,
	input pr_ki_sel_e ki_sel,
	input logic [0:`PR_WORD-1] rz,
	input logic [0:`PR_WORD-1] zp,
	input logic [0:9] rs,
	output logic [0:`PR_WORD-1] l,	// L bus
	output pr_r0_u r0,
	output logic [0:`PR_WORD-1] ki,	// KI bus
	output logic [0:3] dnb_n,
	output logic dqb_n,
	output logic dpn_n,
	output logic zgpn,
	output logic q
);

	logic rf_we;
	logic [2:0] rf_addr;
	logic [1:0] l_src;
	logic r0_we_full;
	logic r0_we_low;
	pr_flag_upd_t r0_flag_we;
	logic zer;

	pr_ctl u_ctl (
		.clk, .arst_n, .cmd, .strobe, .lpc, .upd, .q, .zer_sp, .clm,
		.rf_we, .rf_addr, .l_src, .r0_we_full, .r0_we_low, .r0_flag_we, .zer
	);

	pr_rfile u_rfile (
		.clk, .arst_n, .w, .rf_we, .rf_addr, .l_src, .r0, .l
	);

	pr_r0 u_r0 (
		.clk, .arst_n, .w, .r0_we_full, .r0_we_low, .r0_flag_we, .zer,
		.zs, .s_1, .s0, .carry, .aryt, .ovf, .exy, .exx, .r0
	);

	pr_sysregs u_sysregs (
		.clk, .arst_n, .w, .w_rba, .w_rbb, .w_rbc, .w_bar, .strobe, .zer, .clm,
		.bar_nb, .q_nb, .bp_nb, .pn_nb, .rpn, .ki_sel, .rz, .zp, .rs,
		.q, .dnb_n, .dqb_n, .dpn_n, .zgpn, .ki
	);

endmodule

/* verif/pr_tb_checks.sv */
/*
	Concurrent checks of the register unit ports against the testbench model
	Instantiated inside pr_tb and raises failed at the first mismatch
*/

`include "pr_consts.svh"

module pr_tb_checks import pr_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic [0:`PR_WORD-1] l,	// DUT side
	input pr_r0_u r0,
	input logic [0:`PR_WORD-1] ki,
	input logic [0:3] dnb_n,
	input logic dqb_n,
	input logic dpn_n,
	input logic zgpn,
	input logic q,
	input logic [0:`PR_WORD-1] exp_l,	// Model side
	input pr_r0_u exp_r0,
	input logic [0:`PR_WORD-1] exp_ki,
	input logic [0:6] exp_drv,	// dnb_n, dqb_n, dpn_n, zgpn
	input logic exp_q,
	output logic failed
);

	timeunit 1ns;
	timeprecision 100ps;

	initial failed = 1'b0;

	task automatic raise_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		failed = 1'b1;	// Top stops the run
	endtask

	// Model and DUT sampled together at every edge
	l_matches: assert property (@(posedge clk) disable iff (!arst_n) l == exp_l)
		else raise_error($sformatf("l is %h, model %h", $sampled(l), $sampled(exp_l)));
	r0_matches: assert property (@(posedge clk) disable iff (!arst_n) r0.word == exp_r0.word)
		else raise_error($sformatf("r0 is %h, model %h", $sampled(r0), $sampled(exp_r0)));
	ki_matches: assert property (@(posedge clk) disable iff (!arst_n) ki == exp_ki)
		else raise_error($sformatf("ki is %h, model %h", $sampled(ki), $sampled(exp_ki)));
	drv_matches: assert property (@(posedge clk) disable iff (!arst_n)
		{dnb_n, dqb_n, dpn_n, zgpn} == exp_drv)
		else raise_error($sformatf("bus drivers %b, model %b",
			$sampled({dnb_n, dqb_n, dpn_n, zgpn}), $sampled(exp_drv)));
	q_matches: assert property (@(posedge clk) disable iff (!arst_n) q == exp_q)
		else raise_error($sformatf("q is %b, model %b", $sampled(q), $sampled(exp_q)));

endmodule

/* verif/pr_tb.sv */
/*
	Testbench for the register unit with random and directed stimulus on every port
	A reference model tracks all registers, pr_tb_checks compares the DUT against it
*/

`include "pr_consts.svh"

module pr_tb import pr_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int n_wr = 24;	// Random user register writes
	localparam int n_blr = 8;
	localparam int n_flag = 32;	// Flag group updates
	localparam int n_rb = 24;
	localparam int n_bar = 4;	// NB/Q/BS loads, 32 driver combos each
	localparam int stim_cycles = 35 + 2 * (n_wr + 7 + n_blr + n_flag + n_rb) + 34 * n_bar;
	localparam int timeout_ns = (stim_cycles + 50) * 4;

	logic clk = 1'b0;
	logic arst_n;
	logic [0:`PR_WORD-1] w;
	pr_reg_cmd_t cmd;
	logic strobe, lpc;
	pr_flag_upd_t upd;
	logic zs, s_1, s0, carry, aryt, ovf, exy, exx;	// ALU status
	logic w_rba, w_rbb, w_rbc, w_bar, clm, zer_sp;
	logic bar_nb, q_nb, bp_nb, pn_nb, rpn;	// Driver enables
	pr_ki_sel_e ki_sel;
	logic [0:`PR_WORD-1] rz, zp, l, ki;
	logic [0:9] rs;
	pr_r0_u r0;
	logic [0:3] dnb_n;
	logic dqb_n, dpn_n, zgpn, q;
	int seed = 88395;
	logic check_failed;

	// Reference model
	logic [0:`PR_WORD-1] m_regs [1:`PR_NREGS-1];
	pr_r0_u m_r0;
	logic [0:`PR_WORD-1] m_rb;
	logic [0:3] m_nb;
	logic m_q, m_bs, m_prev;	// m_prev is last cycle's strobe
	logic [0:`PR_WORD-1] exp_l, exp_ki;
	logic [0:6] exp_drv;

	always #2 clk = ~clk;	// 4 ns

	pr dut (.*);

	pr_tb_checks checks (
		.clk, .arst_n, .l, .r0, .ki, .dnb_n, .dqb_n, .dpn_n, .zgpn, .q,
		.exp_l, .exp_r0(m_r0), .exp_ki, .exp_drv, .exp_q(m_q), .failed(check_failed)
	);

	always @(posedge clk or negedge arst_n) begin : ref_model
		pr_r0_u nxt;
		logic first;	// Leading cycle of a strobe
		logic wr;
		logic cmp_l;
		logic cmp_g;
		if (!arst_n) begin
			for (int i = 1; i < `PR_NREGS; i++) begin
				m_regs[i] <= '0;
			end
			m_r0 <= '0;
			m_rb <= '0;
			m_nb <= '0;
			{m_q, m_bs, m_prev} <= '0;
		end else begin
			first = strobe && !m_prev;
			wr = first && cmd.write;
			cmp_l = aryt ? s_1 : !carry;	// Sign or carry compare
			cmp_g = aryt ? (!zs && !s_1) : (carry && !zs);
			m_prev <= strobe;
			if (wr && cmd.addr != 3'd0) m_regs[cmd.addr] <= w;
			nxt = m_r0;
			if (first && (lpc || (wr && cmd.addr == 3'd0 && !m_q))) begin
				nxt.word = w;	// Whole word beats flags
			end else begin
				if (first && upd.ust_z) nxt.fields.flags.z = zs;
				if (first && upd.ust_mc) nxt.fields.flags.m = s0;
				if (first && upd.ust_mc) nxt.fields.flags.c = carry;
				if (first && upd.ust_v) nxt.fields.flags.v = ovf;
				if (first && upd.ust_leg) begin
					nxt.fields.flags.l = cmp_l;
					nxt.fields.flags.e = zs;
					nxt.fields.flags.g = cmp_g;
				end
				if (first && upd.ust_y) nxt.fields.flags.y = exy;
				if (first && upd.ust_x) nxt.fields.flags.x = exx;
				if (wr && cmd.addr == 3'd0) nxt.word[8:15] = w[8:15];	// User mode
			end
			if (zer_sp || clm) nxt.fields.user = '0;
			m_r0 <= nxt;
			if (strobe && w_rba) m_rb[10:15] <= w[10:15];
			if (strobe && w_rbb) m_rb[4:9] <= w[10:15];
			if (strobe && w_rbc) m_rb[0:3] <= w[12:15];
			if (clm) begin
				m_nb <= '0;
				m_bs <= 1'b0;
			end else if (strobe && w_bar) begin
				m_nb <= w[12:15];
				m_bs <= w[11];
			end
			if (zer_sp || clm) m_q <= 1'b0;
			else if (strobe && w_bar) m_q <= w[10];
		end
	end

	// Bus outputs from model state and live inputs
	always_comb begin
		if (cmd.blr) exp_l = {8'h00, m_r0.word[0:7]};	// Flags down a byte
		else if (cmd.read && cmd.addr == 3'd0) exp_l = m_r0.word;
		else if (cmd.read) exp_l = m_regs[cmd.addr];
		else exp_l = '0;
		case (ki_sel)
			ki_rz: exp_ki = rz;
			ki_state: exp_ki = {rs, m_q, m_bs, m_nb};
			ki_rb: exp_ki = m_rb;
			default: exp_ki = zp;
		endcase
		exp_drv[0:3] = bar_nb ? ~m_nb : 4'hf;
		exp_drv[4] = !(q_nb && m_q);
		exp_drv[5] = !((bp_nb && m_bs != `PR_CPU_NUMBER)
			|| (pn_nb && `PR_CPU_NUMBER == 1'b1));
		exp_drv[6] = (rpn == `PR_CPU_NUMBER);
	end

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	// Idle the control inputs and keep ki and driver inputs
	task automatic release_ctl();
		cmd <= '0;
		{strobe, lpc, w_rba, w_rbb, w_rbc, w_bar, zer_sp, clm} <= '0;
		upd <= '0;
	endtask

	task automatic write_reg(input logic [2:0] addr, input logic [0:`PR_WORD-1] data,
		input logic load_all);
		@(posedge clk);
		cmd <= {addr, 1'b0, 1'b1, 1'b0};
		w <= data;
		lpc <= load_all;	// LPC
		strobe <= 1'b1;
		@(posedge clk);
		release_ctl();
	endtask

	task automatic read_reg(input logic [2:0] addr, input logic blr);
		@(posedge clk);
		cmd <= {addr, 1'b1, 1'b0, blr};
		@(posedge clk);
		release_ctl();
	endtask

	task automatic load_bar(input logic [0:`PR_WORD-1] data);
		@(posedge clk);
		w <= data;	// Q bit 10, BS bit 11, NB 12..15
		w_bar <= 1'b1;
		strobe <= 1'b1;
		@(posedge clk);
		release_ctl();
	endtask

	task automatic clear_pulse(input logic sp, input logic master);
		@(posedge clk);
		zer_sp <= sp;
		clm <= master;
		@(posedge clk);
		release_ctl();
	endtask

	initial begin
		arst_n <= 1'b0;
		w <= '0;
		release_ctl();
		{zs, s_1, s0, carry, aryt, ovf, exy, exx} <= '0;
		{bar_nb, q_nb, bp_nb, pn_nb, rpn} <= '0;
		ki_sel <= ki_rz;
		{rz, zp, rs} <= '0;
		repeat (5) @(posedge clk);
		arst_n <= 1'b1;
		// Every user register in turn with random data
		for (int i = 0; i < n_wr; i++) begin
			write_reg(3'd1 + 3'(i % 7), 16'($random(seed)), 1'b0);
		end
		for (int a = 1; a < `PR_NREGS; a++) read_reg(3'(a), 1'b0);
		// R0 full, then user mode, then LPC
		write_reg(3'd0, 16'($random(seed)), 1'b0);
		read_reg(3'd0, 1'b0);
		load_bar(16'h0020 | 16'($random(seed)));	// Sets Q
		write_reg(3'd0, 16'($random(seed)), 1'b0);
		write_reg(3'd0, 16'($random(seed)), 1'b1);
		repeat (n_blr) read_reg(3'($random(seed)), 1'b1);
		// Each flag group in turn over random ALU state
		for (int f = 0; f < n_flag; f++) begin
			@(posedge clk);
			{zs, s_1, s0, carry, ovf, exy, exx} <= 7'($random(seed));
			aryt <= 1'((f / 6) % 2);	// Both compare modes
			upd <= pr_flag_upd_t'(6'b1 << (f % 6));
			strobe <= 1'b1;
			@(posedge clk);
			release_ctl();
		end
		@(posedge clk);
		upd <= '1;	// Loses to LPC
		lpc <= 1'b1;
		w <= 16'($random(seed));
		strobe <= 1'b1;
		@(posedge clk);
		release_ctl();
		// RB fields and KI sources
		for (int k = 0; k < n_rb; k++) begin
			@(posedge clk);
			w <= 16'($random(seed));
			{w_rba, w_rbb, w_rbc} <= 3'b100 >> (k % 3);
			strobe <= 1'b1;
			ki_sel <= pr_ki_sel_e'((k / 3) % 4);
			rz <= 16'($random(seed));
			zp <= 16'($random(seed));
			rs <= 10'($random(seed));
			@(posedge clk);
			release_ctl();
		end
		// Bus drivers over every enable and rpn combination
		ki_sel <= ki_state;
		for (int b = 0; b < n_bar; b++) begin
			load_bar({10'($random(seed)), 2'(b), 4'($random(seed))});	// Each Q and BS pair
			for (int e = 0; e < 32; e++) begin
				@(posedge clk);
				{bar_nb, q_nb, bp_nb, pn_nb, rpn} <= 5'(e);
			end
		end
		// Clears, then a held strobe
		load_bar(16'h003f);
		write_reg(3'd0, 16'hffff, 1'b1);
		clear_pulse(1'b1, 1'b0);	// zer_sp
		load_bar(16'h003f);
		clear_pulse(1'b0, 1'b1);	// clm
		@(posedge clk);
		cmd <= {3'd3, 1'b0, 1'b1, 1'b0};
		w <= 16'($random(seed));
		strobe <= 1'b1;
		repeat (2) begin
			@(posedge clk);
			w <= 16'($random(seed));	// Must not land
		end
		@(posedge clk);
		release_ctl();
		read_reg(3'd3, 1'b0);
		repeat (2) @(posedge clk);
		if (check_failed) begin
			stop_failed("output checks reported errors");
		end else begin
			$display("PASS: all tests");
			$finish;
		end
	end

	always @(posedge check_failed) begin
		stop_failed("stopped at the first failed output check");
	end

	// Watchdog
	initial begin
		#(timeout_ns);
		stop_failed("timeout, the stimulus did not complete in time");
	end

endmodule

/* vlog.f */
+incdir+rtl
rtl/pr_pkg.sv
rtl/pr_ctl.sv
rtl/pr_rfile.sv
rtl/pr_r0.sv
rtl/pr_sysregs.sv
rtl/pr.sv
verif/pr_tb_checks.sv
verif/pr_tb.sv

/* Bender.yml */
package:
  name: pr

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pr_pkg.sv
      - rtl/pr_ctl.sv
      - rtl/pr_rfile.sv
      - rtl/pr_r0.sv
      - rtl/pr_sysregs.sv
      - rtl/pr.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/pr_tb_checks.sv
      - verif/pr_tb.sv
